// ==== all.f ====
clk_types_pkg.sv
wb_pkg.sv
wb_reg_port.sv
lock_monitor.sv
reset_sequencer.sv
domain_reset_sync.sv
clock_reset_ctrl.sv
clock_reset_props.sv
tb_clock_reset.sv

// ==== clk_types_pkg.sv ====
package clk_types_pkg;

  // Reset sequencer states, reported in STATUS[2:0]
  typedef enum logic [2:0] {
    SEQ_HOLD        = 3'd0, // PLL held in reset, all domains in reset
    SEQ_WAIT_LOCK   = 3'd1, // PLL running, waiting for a stable lock
    SEQ_RELEASE_SIG = 3'd2, // Signal-capture domain released, settling
    SEQ_RUN         = 3'd3  // Both domains out of reset
  } seq_state_e;

  // Divider settings that go straight out to the PLL primitive
  typedef struct packed {
    logic [5:0] idiv;  // Input divider
    logic [5:0] fbdiv; // Feedback divider
    logic [6:0] odiv;  // Output divider
    logic [1:0] sdiv;  // Secondary divider
  } pll_cfg_t;

  // Reset requests, all on the bus clock, high means hold in reset
  typedef struct packed {
    logic pll; // To the PLL reset pin
    logic sig; // Signal-capture domain
    logic vis; // Visibility-correlator domain
  } rst_req_t;

  // Lock qualification
  localparam int LOCK_SYNC_STAGES   = 2;  // Flops in the lock synchronizer
  localparam int LOCK_STABLE_CYCLES = 16; // Consecutive high cycles to qualify

  // Gap between sig release and vis release, in bus cycles
  localparam int SETTLE_CYCLES = 8;

  // Destination-clock edges before a domain reset releases
  localparam int RST_SYNC_STAGES = 3;

  // Counter widths
  localparam int LOCK_CNT_W   = $clog2(LOCK_STABLE_CYCLES + 1);
  localparam int SETTLE_CNT_W = $clog2(SETTLE_CYCLES);

endpackage

// ==== clock_reset_ctrl.sv ====
`timescale 1ns/1ps

module clock_reset_ctrl (
  input  logic                    bus_clock,
  input  logic                    rst_n,
  input  logic                    sig_clock,  // Signal-capture clock
  input  logic                    vis_clock,  // Visibility-correlator clock
  input  wb_pkg::wb_req_t         wb_req,
  output wb_pkg::wb_rsp_t         wb_rsp,
  input  logic                    pll_lock,
  output clk_types_pkg::pll_cfg_t pll_cfg,
  output logic                    pll_reset,
  output logic                    sig_reset,
  output logic                    vis_reset
);

  logic                      run;
  logic                      soft_reset;
  logic                      lock_sync;
  logic                      lock_stable;
  logic                      loss_event;
  clk_types_pkg::seq_state_e state;
  clk_types_pkg::rst_req_t   rst_req;
  logic                      vis_req;

  wb_reg_port wb_reg_port_i (
    .bus_clock(bus_clock), .rst_n(rst_n),
    .wb_req(wb_req), .wb_rsp(wb_rsp),
    .run(run), .soft_reset(soft_reset), .pll_cfg(pll_cfg),
    .state(state), .lock_sync(lock_sync), .lock_stable(lock_stable),
    .loss_event(loss_event)
  );

  lock_monitor lock_monitor_i (
    .bus_clock(bus_clock), .rst_n(rst_n), .pll_lock(pll_lock),
    .lock_sync(lock_sync), .lock_stable(lock_stable), .loss_event(loss_event)
  );

  reset_sequencer reset_sequencer_i (
    .bus_clock(bus_clock), .rst_n(rst_n),
    .run(run), .soft_reset(soft_reset), .lock_stable(lock_stable),
    .state(state), .rst_req(rst_req)
  );

  assign pll_reset = rst_req.pll;

  // The slow sig clock can lag the vis release, so vis also waits for sig_reset
  assign vis_req = rst_req.vis || sig_reset;

  domain_reset_sync #(.N(clk_types_pkg::RST_SYNC_STAGES)) sig_reset_sync_i (
    .clock(sig_clock), .rst_n(rst_n), .reset_req(rst_req.sig), .reset(sig_reset)
  );

  domain_reset_sync #(.N(clk_types_pkg::RST_SYNC_STAGES)) vis_reset_sync_i (
    .clock(vis_clock), .rst_n(rst_n), .reset_req(vis_req), .reset(vis_reset)
  );

endmodule

// ==== clock_reset_props.sv ====
`timescale 1ns/1ps

module clock_reset_props (
  input logic                      bus_clock,
  input logic                      rst_n,
  input wb_pkg::wb_rsp_t           wb_rsp,
  input clk_types_pkg::seq_state_e state,
  input clk_types_pkg::rst_req_t   rst_req
);

  // vis leaves reset only once sig has been out for the whole settle window
  vis_after_sig: assert property (@(posedge bus_clock) disable iff (!rst_n)
    $fell(rst_req.vis) |->
      !rst_req.sig && $past(!rst_req.sig, clk_types_pkg::SETTLE_CYCLES))
    else $error("vis released before sig settled out of reset");

  ack_one_cycle: assert property (@(posedge bus_clock) disable iff (!rst_n)
    wb_rsp.ack |=> !wb_rsp.ack) else $error("Wishbone ack high for two cycles");

  pll_reset_in_hold: assert property (@(posedge bus_clock) disable iff (!rst_n)
    (state == clk_types_pkg::SEQ_HOLD) |-> rst_req.pll)
    else $error("pll_reset low in SEQ_HOLD");

endmodule

// Sequencer side has no bus
bind reset_sequencer clock_reset_props seq_props_i (
  .bus_clock(bus_clock), .rst_n(rst_n), .wb_rsp('0), .state(state), .rst_req(rst_req)
);

// Port side sees no reset requests
bind wb_reg_port clock_reset_props port_props_i (
  .bus_clock(bus_clock), .rst_n(rst_n), .wb_rsp(wb_rsp), .state(state), .rst_req('1)
);

// ==== domain_reset_sync.sv ====
`timescale 1ns/1ps

module domain_reset_sync #(
  parameter int N = 3 // Destination edges before release
) (
  input  logic clock,     // Destination domain clock
  input  logic rst_n,     // Global reset
  input  logic reset_req, // Request, may come from any domain
  output logic reset      // Active high, to the domain
);

  logic [N-1:0] stages_q;
  logic         clr_n; // Either source clears the chain at once

  assign clr_n = rst_n && !reset_req;

  // Assert asynchronously, shift zeros in on the destination clock
  always_ff @(posedge clock or negedge clr_n) begin
    if (!clr_n)
      stages_q <= '1;
    else
      stages_q <= stages_q << 1; // Works for any N
  end

  assign reset = stages_q[N-1]; // Low after N clean edges

endmodule

// ==== lock_monitor.sv ====
`timescale 1ns/1ps

module lock_monitor (
  input  logic bus_clock,
  input  logic rst_n,
  input  logic pll_lock,    // Asynchronous, from the PLL
  output logic lock_sync,   // Raw lock after the synchronizer
  output logic lock_stable, // Lock held long enough to trust
  output logic loss_event   // One cycle on each fall of lock_stable
);

  localparam int STAGES = clk_types_pkg::LOCK_SYNC_STAGES;
  localparam int CNT_W  = clk_types_pkg::LOCK_CNT_W;
  localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(clk_types_pkg::LOCK_STABLE_CYCLES);

  logic [STAGES-1:0] sync_q;
  logic [CNT_W-1:0]  cnt_q;    // Consecutive synchronized-high cycles
  logic              stable_q; // lock_stable one cycle back

  // Two-flop chain, oldest sample at the top
  always_ff @(posedge bus_clock or negedge rst_n) begin
    if (!rst_n)
      sync_q <= '0;
    else
      sync_q <= (sync_q << 1) | STAGES'(pll_lock);
  end

  assign lock_sync = sync_q[STAGES-1];

  // Any low sample restarts the count, so glitches never qualify
  always_ff @(posedge bus_clock or negedge rst_n) begin
    if (!rst_n)
      cnt_q <= '0;
    else if (!lock_sync)
      cnt_q <= '0;
    else if (cnt_q != CNT_MAX)
      cnt_q <= cnt_q + 1'b1;
  end

  // Falls with lock_sync, not a cycle later
  assign lock_stable = lock_sync && (cnt_q == CNT_MAX);

  always_ff @(posedge bus_clock or negedge rst_n) begin
    if (!rst_n)
      stable_q <= 1'b0;
    else
      stable_q <= lock_stable;
  end

  assign loss_event = stable_q && !lock_stable; // Falling edge detect

endmodule

// ==== reset_sequencer.sv ====
`timescale 1ns/1ps

module reset_sequencer (
  input  logic                      bus_clock,
  input  logic                      rst_n,
  input  logic                      run,
  input  logic                      soft_reset,  // One-cycle pulse from CTRL
  input  logic                      lock_stable,
  output clk_types_pkg::seq_state_e state,
  output clk_types_pkg::rst_req_t   rst_req
);

  localparam int CNT_W = clk_types_pkg::SETTLE_CNT_W;
  localparam logic [CNT_W-1:0] SETTLE_LAST = CNT_W'(clk_types_pkg::SETTLE_CYCLES - 1);

  clk_types_pkg::seq_state_e state_q;
  clk_types_pkg::seq_state_e state_d;
  logic [CNT_W-1:0]          settle_q;
  logic [CNT_W-1:0]          settle_d;
  clk_types_pkg::rst_req_t   req_q;
  clk_types_pkg::rst_req_t   req_d;
  logic                      abort; // Run dropped or soft reset, from any state

  assign abort = soft_reset || !run;

  // Next state and settle counter
  always_comb begin
    state_d  = state_q;
    settle_d = settle_q;
    case (state_q)
      clk_types_pkg::SEQ_HOLD: begin
        if (!abort)
          state_d = clk_types_pkg::SEQ_WAIT_LOCK; // Let the PLL run
      end
      clk_types_pkg::SEQ_WAIT_LOCK: begin
        if (abort) begin
          state_d = clk_types_pkg::SEQ_HOLD;
        end else if (lock_stable) begin
          state_d  = clk_types_pkg::SEQ_RELEASE_SIG;
          settle_d = '0; // Start the settle window
        end
      end
      clk_types_pkg::SEQ_RELEASE_SIG: begin
        if (abort || !lock_stable)
          state_d = clk_types_pkg::SEQ_HOLD;
        else if (settle_q == SETTLE_LAST)
          state_d = clk_types_pkg::SEQ_RUN;
        else
          settle_d = settle_q + 1'b1;
      end
      clk_types_pkg::SEQ_RUN: begin
        if (abort || !lock_stable)
          state_d = clk_types_pkg::SEQ_HOLD; // Lock lost, start over
      end
      default: state_d = clk_types_pkg::SEQ_HOLD;
    endcase
  end

  // Requests decoded from the next state so they register glitch free
  // and line up with the state register
  always_comb begin
    req_d.pll = (state_d == clk_types_pkg::SEQ_HOLD);
    req_d.sig = !((state_d == clk_types_pkg::SEQ_RELEASE_SIG) ||
                  (state_d == clk_types_pkg::SEQ_RUN));
    req_d.vis = (state_d != clk_types_pkg::SEQ_RUN); // Only ever after sig
  end

  always_ff @(posedge bus_clock or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= clk_types_pkg::SEQ_HOLD;
      settle_q <= '0;
      req_q    <= '{pll: 1'b1, sig: 1'b1, vis: 1'b1}; // Everything held
    end else begin
      state_q  <= state_d;
      settle_q <= settle_d;
      req_q    <= req_d;
    end
  end

  assign state   = state_q;
  assign rst_req = req_q;

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the clock and reset control testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_clock_reset \
  -Mdir obj_dir -o tb_sim -f all.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Something failed" "$LOG"; then
  echo "Testbench reported failures"
  exit 1
fi
if ! grep -q "Everything OK" "$LOG"; then
  echo "Testbench did not finish"
  exit 1
fi
exit 0

// ==== tb_clock_reset.sv ====
`timescale 1ns/1ps

module tb_clock_reset;

  localparam logic [31:0] RANDOM_SEED = 32'h51e8fc74;
  localparam int LOCK_DELAY     = 10; // Bus cycles from pll_reset low to modeled lock
  localparam int RELEASE_EDGES  = 3;  // Domain clock edges allowed for a release
  localparam int GLITCH_PULSES  = 8;
  // Bus cycles from the lock rise at the DUT input to SEQ_RUN
  localparam int RUN_DELAY      = clk_types_pkg::LOCK_SYNC_STAGES +
                                  clk_types_pkg::LOCK_STABLE_CYCLES + 1 +
                                  clk_types_pkg::SETTLE_CYCLES;
  // One start-up with about 7 bus cycles per sig_clock period
  localparam int START_CYCLES   = LOCK_DELAY + RUN_DELAY + 2 * RELEASE_EDGES * 7;
  localparam int TEST_CYCLES    = 60 * 4 + 4 * START_CYCLES + GLITCH_PULSES * 24 + 60;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  logic                    bus_clock = 1'b0;
  logic                    sig_clock = 1'b0;
  logic                    vis_clock = 1'b0;
  logic                    rst_n;
  wb_pkg::wb_req_t         wb_req;
  wb_pkg::wb_rsp_t         wb_rsp;
  logic                    pll_lock = 1'b0;
  clk_types_pkg::pll_cfg_t pll_cfg;
  logic                    pll_reset;
  logic                    sig_reset;
  logic                    vis_reset;

  logic lock_override;     // Test takes the lock line away from the model
  logic lock_forced;       // Lock level while overridden
  int   lock_count  = 0;
  int   sig_edges   = 0;   // sig_clock edges spent releasing sig_reset
  int   vis_edges   = 0;
  int   cycle_count = 0;
  int   errors      = 0;
  int   test_errors = 0;   // Error count when the current test began
  int   tests_run    = 0;
  int   tests_passed = 0;

  always #10 bus_clock = ~bus_clock; // 20 ns
  always #61 sig_clock = ~sig_clock; // 122 ns
  always #4  vis_clock = ~vis_clock; // 8 ns

  clock_reset_ctrl clock_reset_ctrl_i (
    .bus_clock(bus_clock), .rst_n(rst_n), .sig_clock(sig_clock), .vis_clock(vis_clock),
    .wb_req(wb_req), .wb_rsp(wb_rsp), .pll_lock(pll_lock), .pll_cfg(pll_cfg),
    .pll_reset(pll_reset), .sig_reset(sig_reset), .vis_reset(vis_reset)
  );

  // PLL model locks a fixed delay after its reset drops
  always @(posedge bus_clock) begin
    if (!rst_n || pll_reset)
      lock_count <= 0;
    else if (lock_count < LOCK_DELAY)
      lock_count <= lock_count + 1;
    if (lock_override)
      pll_lock <= lock_forced;
    else
      pll_lock <= rst_n && !pll_reset && (lock_count == LOCK_DELAY);
  end

  // Edges seen while the request is low and the domain is still in reset
  always @(posedge sig_clock) begin
    if (clock_reset_ctrl_i.rst_req.sig)
      sig_edges <= 0;
    else if (sig_reset)
      sig_edges <= sig_edges + 1;
  end

  always @(posedge vis_clock) begin
    if (clock_reset_ctrl_i.vis_req)
      vis_edges <= 0;
    else if (vis_reset)
      vis_edges <= vis_edges + 1;
  end

  always @(posedge bus_clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES) begin
      $display("Timeout, run stopped after %0d bus cycles", cycle_count);
      $display("Something failed");
      $finish;
    end
  end

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_state(input string name, input clk_types_pkg::seq_state_e got,
                             input clk_types_pkg::seq_state_e exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_cfg(input string name, input clk_types_pkg::pll_cfg_t got,
                           input clk_types_pkg::pll_cfg_t exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  // Ack must show on the first negedge after the edge that saw stb
  task automatic wait_for_ack(input logic [3:0] adr);
    int n;
    n = 0;
    do begin
      @(negedge bus_clock);
      n++;
    end while (!wb_rsp.ack && n < 8);
    if (!wb_rsp.ack) begin
      $display("No ack for the access to address %0d", adr);
      errors++;
    end else if (n != 2) begin
      $display("Ack for address %0d came %0d cycles after stb instead of 1", adr, n - 1);
      errors++;
    end
  endtask

  task automatic wb_write(input logic [3:0] adr, input logic [31:0] dat);
    @(posedge bus_clock);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
    wait_for_ack(adr);
    @(posedge bus_clock);
    wb_req <= '0; // End of the cycle
  endtask

  task automatic wb_read(input logic [3:0] adr, output logic [31:0] dat);
    @(posedge bus_clock);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: 32'h0};
    wait_for_ack(adr);
    dat = wb_rsp.dat; // Valid while ack is high
    @(posedge bus_clock);
    wb_req <= '0;
  endtask

  task automatic wait_for_state(input clk_types_pkg::seq_state_e exp, input int limit);
    int n;
    n = 0;
    do begin
      @(negedge bus_clock);
      n++;
    end while (clock_reset_ctrl_i.state != exp && n < limit);
    if (clock_reset_ctrl_i.state != exp) begin
      $display("State did not reach %s within %0d cycles", exp.name(), limit);
      errors++;
    end
  endtask

  task automatic start_test();
    test_errors = errors;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == test_errors) begin
      tests_passed++;
      $display("PASS  %s", name);
    end else begin
      $display("FAIL  %s, %0d errors", name, errors - test_errors);
    end
  endtask

  task automatic register_access();
    logic [31:0] w;
    logic [31:0] rd;
    start_test();
    check_bit("ack after reset", wb_rsp.ack, 1'b0);
    check_bit("pll_reset after reset", pll_reset, 1'b1);
    check_bit("sig_reset after reset", sig_reset, 1'b1);
    check_bit("vis_reset after reset", vis_reset, 1'b1);
    check_state("state after reset", clock_reset_ctrl_i.state, clk_types_pkg::SEQ_HOLD);
    w = 32'h0;
    for (int i = 0; i < 20; i++) begin
      w = $urandom;
      wb_write(wb_pkg::REG_PLL_CFG, w);
      wb_read(wb_pkg::REG_PLL_CFG, rd);
      check_word("PLL_CFG", rd, w & 32'h001f_ffff); // Only 21 bits exist
      check_cfg("pll_cfg", pll_cfg, clk_types_pkg::pll_cfg_t'(w[20:0]));
    end
    wb_write(4'd9, 32'hffff_ffff); // Ignored
    for (int a = 4; a < 16; a++) begin
      wb_read(4'(a), rd);
      check_word("unmapped read", rd, 32'h0);
    end
    wb_read(wb_pkg::REG_PLL_CFG, rd);
    check_word("PLL_CFG after unmapped write", rd, w & 32'h001f_ffff);
    finish_test("register access");
  endtask

  task automatic ordered_startup();
    int n;
    int pll_fall;
    int sig_fall;
    int vis_fall;
    int lock_rise;
    int run_at;
    logic [31:0] rd;
    start_test();
    pll_fall  = -1;
    sig_fall  = -1;
    vis_fall  = -1;
    lock_rise = -1;
    run_at    = -1;
    wb_write(wb_pkg::REG_CTRL, 32'h1 << wb_pkg::CTRL_RUN_BIT);
    n = 0;
    while (vis_fall < 0 && n < 4 * START_CYCLES) begin
      @(negedge bus_clock);
      n++;
      if (pll_fall < 0 && !pll_reset) pll_fall = n;
      if (sig_fall < 0 && !sig_reset) sig_fall = n;
      if (vis_fall < 0 && !vis_reset) vis_fall = n;
      if (lock_rise < 0 && pll_lock) lock_rise = n; // As the DUT samples it
      if (run_at < 0 && clock_reset_ctrl_i.state == clk_types_pkg::SEQ_RUN) run_at = n;
    end
    if (vis_fall < 0) begin
      $display("vis_reset never released after run was set");
      errors++;
    end else begin
      if (pll_fall < 0 || (sig_fall >= 0 && pll_fall >= sig_fall)) begin
        $display("pll_reset did not fall before the domain resets released");
        errors++;
      end
      if (sig_fall < 0 || sig_fall >= vis_fall) begin
        $display("vis_reset released before sig_reset");
        errors++;
      end
      check_word("cycles from lock to SEQ_RUN", 32'(run_at - lock_rise), 32'(RUN_DELAY));
    end
    if (sig_edges > RELEASE_EDGES || vis_edges > RELEASE_EDGES) begin
      $display("Domain release took %0d sig / %0d vis edges, limit %0d",
               sig_edges, vis_edges, RELEASE_EDGES);
      errors++;
    end
    wb_read(wb_pkg::REG_STATUS, rd);
    check_state("STATUS state", clk_types_pkg::seq_state_e'(rd[2:0]), clk_types_pkg::SEQ_RUN);
    check_bit("STATUS lock_sync", rd[wb_pkg::STATUS_LOCK_SYNC_BIT], 1'b1);
    check_bit("STATUS lock_stable", rd[wb_pkg::STATUS_LOCK_STABLE_BIT], 1'b1);
    finish_test("ordered start-up");
  endtask

  task automatic lock_loss_recovery();
    logic [31:0] base;
    logic [31:0] rd;
    start_test();
    wb_read(wb_pkg::REG_LOSS_COUNT, base);
    @(posedge bus_clock);
    lock_override <= 1'b1;
    lock_forced   <= 1'b0; // PLL drops lock
    wait_for_state(clk_types_pkg::SEQ_HOLD, 20);
    check_bit("pll_reset on lock loss", pll_reset, 1'b1);
    check_bit("sig_reset on lock loss", sig_reset, 1'b1);
    check_bit("vis_reset on lock loss", vis_reset, 1'b1);
    wb_read(wb_pkg::REG_STATUS, rd);
    check_bit("STATUS sticky", rd[wb_pkg::STATUS_STICKY_BIT], 1'b1);
    wb_read(wb_pkg::REG_LOSS_COUNT, rd);
    check_word("LOSS_COUNT", rd, base + 32'h1);
    wb_write(wb_pkg::REG_STATUS, 32'h1 << wb_pkg::STATUS_STICKY_BIT);
    wb_read(wb_pkg::REG_STATUS, rd);
    check_bit("STATUS sticky after clear", rd[wb_pkg::STATUS_STICKY_BIT], 1'b0);
    finish_test("lock loss");
  endtask

  task automatic glitch_filter();
    logic [31:0] base;
    logic [31:0] rd;
    int          len;
    int          gap;
    logic        held;
    start_test();
    wait_for_state(clk_types_pkg::SEQ_WAIT_LOCK, 10);
    wb_read(wb_pkg::REG_LOSS_COUNT, base);
    held = 1'b1;
    for (int p = 0; p < GLITCH_PULSES; p++) begin
      len = 1 + int'($urandom % (clk_types_pkg::LOCK_STABLE_CYCLES - 1)); // Never qualifies
      gap = 3 + int'($urandom % 4);
      for (int c = 0; c < len + gap; c++) begin
        @(posedge bus_clock);
        lock_forced <= (c < len);
        @(negedge bus_clock);
        if (clock_reset_ctrl_i.state != clk_types_pkg::SEQ_WAIT_LOCK || !sig_reset || !vis_reset)
          held = 1'b0;
      end
    end
    check_bit("domains held through lock glitches", held, 1'b1);
    check_state("state after glitches", clock_reset_ctrl_i.state,
                clk_types_pkg::SEQ_WAIT_LOCK);
    wb_read(wb_pkg::REG_LOSS_COUNT, rd);
    check_word("LOSS_COUNT after glitches", rd, base);
    @(posedge bus_clock);
    lock_override <= 1'b0; // Model locks again
    finish_test("lock glitch filter");
  endtask

  task automatic run_clear_soft_reset();
    logic [31:0] rd;
    start_test();
    wait_for_state(clk_types_pkg::SEQ_RUN, START_CYCLES);
    wb_write(wb_pkg::REG_CTRL, 32'h0);
    wait_for_state(clk_types_pkg::SEQ_HOLD, 10);
    check_bit("pll_reset after run clear", pll_reset, 1'b1);
    wb_read(wb_pkg::REG_STATUS, rd);
    check_state("STATUS state after run clear", clk_types_pkg::seq_state_e'(rd[2:0]),
                clk_types_pkg::SEQ_HOLD);
    wb_write(wb_pkg::REG_CTRL, 32'h1 << wb_pkg::CTRL_RUN_BIT);
    wait_for_state(clk_types_pkg::SEQ_RUN, START_CYCLES);
    wb_write(wb_pkg::REG_CTRL,
             (32'h1 << wb_pkg::CTRL_RUN_BIT) | (32'h1 << wb_pkg::CTRL_SOFT_RST_BIT));
    wait_for_state(clk_types_pkg::SEQ_HOLD, 4);
    check_bit("pll_reset after soft reset", pll_reset, 1'b1);
    wb_read(wb_pkg::REG_CTRL, rd);
    check_word("CTRL", rd, 32'h1 << wb_pkg::CTRL_RUN_BIT); // Soft reset bit reads 0
    finish_test("run clear and soft reset");
  endtask

  initial begin
    void'($urandom(RANDOM_SEED));
    rst_n         = 1'b0;
    wb_req        = '0;
    lock_override = 1'b0;
    lock_forced   = 1'b0;
    repeat (4) @(posedge bus_clock);
    rst_n <= 1'b1;
    register_access();
    ordered_startup();
    lock_loss_recovery();
    glitch_filter();
    run_clear_soft_reset();
    $display("%0d of %0d tests passed, %0d errors", tests_passed, tests_run, errors);
    if (errors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

// ==== wb_pkg.sv ====
package wb_pkg;

  // Master to slave, classic cycle
  typedef struct packed {
    logic        cyc; // Bus cycle in progress
    logic        stb; // Strobe, valid access
    logic        we;  // Write enable
    logic [3:0]  adr; // Word address
    logic [31:0] dat; // Write data
  } wb_req_t;

  // Slave to master
  typedef struct packed {
    logic        ack; // One-cycle acknowledge
    logic [31:0] dat; // Read data, valid with ack
  } wb_rsp_t;

  // Word addresses of the register map
  typedef enum logic [3:0] {
    REG_CTRL       = 4'd0, // Run and soft reset
    REG_PLL_CFG    = 4'd1, // Divider settings, low 21 bits
    REG_STATUS     = 4'd2, // State, lock and sticky loss flag
    REG_LOSS_COUNT = 4'd3  // Saturating lock-loss count
  } reg_addr_e;

  // CTRL bits
  localparam int CTRL_RUN_BIT      = 0;
  localparam int CTRL_SOFT_RST_BIT = 1; // Self-clearing, reads as zero

  // STATUS bits, state lives in 2:0
  localparam int STATUS_LOCK_SYNC_BIT   = 3;
  localparam int STATUS_LOCK_STABLE_BIT = 4;
  localparam int STATUS_STICKY_BIT      = 8; // Write 1 to clear

endpackage

// ==== wb_reg_port.sv ====
`timescale 1ns/1ps

module wb_reg_port (
  input  logic                      bus_clock,
  input  logic                      rst_n,
  input  wb_pkg::wb_req_t           wb_req,
  output wb_pkg::wb_rsp_t           wb_rsp,
  output logic                      run,
  output logic                      soft_reset,
  output clk_types_pkg::pll_cfg_t   pll_cfg,
  input  clk_types_pkg::seq_state_e state,
  input  logic                      lock_sync,
  input  logic                      lock_stable,
  input  logic                      loss_event
);

  logic                     ack_q;
  logic [31:0]              rd_dat_q;
  logic [31:0]              rd_mux;
  logic                     access;   // First cycle of a new access
  logic                     wr;
  wb_pkg::reg_addr_e        addr;
  logic                     run_q;
  logic                     soft_q;
  clk_types_pkg::pll_cfg_t  cfg_q;
  logic                     sticky_q;
  logic [7:0]               loss_cnt_q;

  assign addr   = wb_pkg::reg_addr_e'(wb_req.adr);
  assign access = wb_req.cyc && wb_req.stb && !ack_q; // No second ack while master drops stb
  assign wr     = access && wb_req.we;

  // Register read mux, unmapped words read zero
  always_comb begin
    rd_mux = '0;
    case (addr)
      wb_pkg::REG_CTRL:       rd_mux[wb_pkg::CTRL_RUN_BIT] = run_q; // Soft reset bit stays 0
      wb_pkg::REG_PLL_CFG:    rd_mux[$bits(clk_types_pkg::pll_cfg_t)-1:0] = cfg_q;
      wb_pkg::REG_STATUS: begin
        rd_mux[2:0]                           = state;
        rd_mux[wb_pkg::STATUS_LOCK_SYNC_BIT]   = lock_sync;
        rd_mux[wb_pkg::STATUS_LOCK_STABLE_BIT] = lock_stable;
        rd_mux[wb_pkg::STATUS_STICKY_BIT]      = sticky_q;
      end
      wb_pkg::REG_LOSS_COUNT: rd_mux[7:0] = loss_cnt_q;
      default:                rd_mux = '0;
    endcase
  end

  always_ff @(posedge bus_clock or negedge rst_n) begin
    if (!rst_n) begin
      ack_q      <= 1'b0;
      run_q      <= 1'b0;
      soft_q     <= 1'b0;
      cfg_q      <= '0;
      sticky_q   <= 1'b0;
      loss_cnt_q <= '0;
    end else begin
      ack_q  <= access; // Exactly one cycle, on the edge after stb
      soft_q <= wr && (addr == wb_pkg::REG_CTRL) && wb_req.dat[wb_pkg::CTRL_SOFT_RST_BIT];
      if (wr && (addr == wb_pkg::REG_CTRL))
        run_q <= wb_req.dat[wb_pkg::CTRL_RUN_BIT];
      if (wr && (addr == wb_pkg::REG_PLL_CFG))
        cfg_q <= clk_types_pkg::pll_cfg_t'(wb_req.dat[$bits(clk_types_pkg::pll_cfg_t)-1:0]);
      // A new loss wins over a clear on the same edge
      if (loss_event)
        sticky_q <= 1'b1;
      else if (wr && (addr == wb_pkg::REG_STATUS) && wb_req.dat[wb_pkg::STATUS_STICKY_BIT])
        sticky_q <= 1'b0;
      if (loss_event && (loss_cnt_q != 8'hff))
        loss_cnt_q <= loss_cnt_q + 8'd1; // Saturates at 255
    end
  end

  // Read data captured with the access, held while ack is high
  always_ff @(posedge bus_clock) begin
    if (access)
      rd_dat_q <= rd_mux;
  end

  assign wb_rsp     = '{ack: ack_q, dat: rd_dat_q};
  assign run        = run_q;
  assign soft_reset = soft_q;
  assign pll_cfg    = cfg_q; // Drives the PLL dividers directly

endmodule
